/* verilog/mem_arb_pkg.sv */
// memory port arbiter shared definitions
// widths, bus commands, access sizes and tag owner encoding
// used by the selector, the tag table and the testbench

package mem_arb_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // default address width of the port
    parameter int xlen = 32;

    // tag field width, zero tag reserved
    parameter int mem_tag_width = 4;

    // one table entry per tag value, entry 0 unused
    parameter int num_tags = 2 ** mem_tag_width;

    // doubleword memory data
    typedef logic [63:0] mem_data_t;

    // transaction tag, zero means none or refused
    typedef logic [mem_tag_width-1:0] mem_tag_t;

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////

    // memory command on the shared port
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // access size of a command
    typedef enum logic [1:0] {
        size_byte   = 2'h0,
        size_half   = 2'h1,
        size_word   = 2'h2,
        size_double = 2'h3
    } mem_size_t;

    // which side owns an outstanding load tag
    typedef enum logic [1:0] {
        own_none  = 2'h0,
        own_data  = 2'h1,
        own_fetch = 2'h2
    } requester_t;

endpackage

/* verilog/request_select.sv */
// request select for the shared memory port
// data side has priority, fetch issues doubleword loads when the data side is idle
// steers the same-cycle response back and reports accepted loads for tag tracking

`timescale 1ns/1ps

module request_select #(
    parameter int addr_width = 32
) (
    // fetch side
    input  logic                      fetch_request,
    input  logic [addr_width-1:0]     fetch_addr,

    // data side
    input  mem_arb_pkg::bus_command_t data_command,
    input  logic [addr_width-1:0]     data_addr,
    input  mem_arb_pkg::mem_data_t    data_wdata,
    input  mem_arb_pkg::mem_size_t    data_size,

    // same-cycle answer from memory
    input  mem_arb_pkg::mem_tag_t     mem_response,

    // command to memory
    output mem_arb_pkg::bus_command_t mem_command,
    output logic [addr_width-1:0]     mem_addr,
    output mem_arb_pkg::mem_data_t    mem_wdata,
    output mem_arb_pkg::mem_size_t    mem_size,

    // acceptance back to requesters
    output mem_arb_pkg::mem_tag_t     fetch_response,
    output mem_arb_pkg::mem_tag_t     data_response,
    output logic                      fetch_stall,
    output logic                      data_stall,

    // accepted load, to the tag table
    output mem_arb_pkg::requester_t   issue_owner,
    output mem_arb_pkg::mem_tag_t     issue_tag
);

    logic data_present;
    logic fetch_on_bus;
    logic accepted;

    ////////////////////////////////////////////////////////////
    // command mux
    ////////////////////////////////////////////////////////////

    // any data command takes the port
    assign data_present = (data_command != mem_arb_pkg::bus_none);

    // fetch only goes out when data is idle
    assign fetch_on_bus = fetch_request && !data_present;

    always_comb begin
        if (data_present) begin
            mem_command = data_command;
            mem_addr    = data_addr;
            mem_wdata   = data_wdata;
            mem_size    = data_size;
        end else begin
            // instruction fetch, always a full doubleword
            mem_command = fetch_request ? mem_arb_pkg::bus_load : mem_arb_pkg::bus_none;
            mem_addr    = fetch_addr;
            mem_wdata   = '0;
            mem_size    = mem_arb_pkg::size_double;
        end
    end

    ////////////////////////////////////////////////////////////
    // response steering and stalls
    ////////////////////////////////////////////////////////////

    // nonzero response is the tag of an accepted command
    assign accepted = (mem_response != '0);

    // only the side that owned the bus hears the tag
    assign data_response  = data_present ? mem_response : '0;
    assign fetch_response = fetch_on_bus ? mem_response : '0;

    // refused data command must be held
    assign data_stall = data_present && !accepted;

    // fetch waits when refused or when pushed off by data
    assign fetch_stall = fetch_request && !(fetch_on_bus && accepted);

    ////////////////////////////////////////////////////////////
    // load issue report
    ////////////////////////////////////////////////////////////

    always_comb begin
        issue_owner = mem_arb_pkg::own_none;
        // stores never return data, so nothing to record
        if (accepted && mem_command == mem_arb_pkg::bus_load) begin
            issue_owner = data_present ? mem_arb_pkg::own_data : mem_arb_pkg::own_fetch;
        end
        issue_tag = (issue_owner != mem_arb_pkg::own_none) ? mem_response : '0;
    end

endmodule

/* verilog/tag_owner_table.sv */
// tag owner table for the shared memory port
// records which side issued each accepted load tag
// routes returning load data to that side and frees the entry

`timescale 1ns/1ps

module tag_owner_table (
    input  logic                    clock,
    input  logic                    reset,

    // accepted load from the selector
    input  mem_arb_pkg::requester_t issue_owner,
    input  mem_arb_pkg::mem_tag_t   issue_tag,

    // returning load data from memory
    input  mem_arb_pkg::mem_tag_t   mem_tag,
    input  mem_arb_pkg::mem_data_t  mem_rdata,

    // routed returns
    output mem_arb_pkg::mem_tag_t   fetch_tag,
    output mem_arb_pkg::mem_data_t  fetch_rdata,
    output mem_arb_pkg::mem_tag_t   data_tag,
    output mem_arb_pkg::mem_data_t  data_rdata
);

    // one owner per tag value
    mem_arb_pkg::requester_t owner_table [mem_arb_pkg::num_tags];
    mem_arb_pkg::requester_t owner_next  [mem_arb_pkg::num_tags];

    // owner of the tag coming back this cycle
    mem_arb_pkg::requester_t ret_owner;
    logic                    ret_valid;
    logic                    issue_valid;

    ////////////////////////////////////////////////////////////
    // table update
    ////////////////////////////////////////////////////////////

    // zero tag means nothing is returning
    assign ret_valid = (mem_tag != '0);

    // tag zero is the refused answer, never an entry
    assign issue_valid = (issue_owner != mem_arb_pkg::own_none) && (issue_tag != '0);

    always_comb begin
        owner_next = owner_table;
        // free on return
        if (ret_valid) begin
            owner_next[mem_tag] = mem_arb_pkg::own_none;
        end
        // a re-issue of the tag just freed keeps the new owner
        if (issue_valid) begin
            owner_next[issue_tag] = issue_owner;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_arb_pkg::num_tags; i++) begin
                owner_table[i] <= mem_arb_pkg::own_none;
            end
        end else begin
            owner_table <= owner_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // return routing
    ////////////////////////////////////////////////////////////

    // lookup uses the registered table, so a return can come
    // at the earliest one cycle after acceptance
    assign ret_owner = owner_table[mem_tag];

    always_comb begin
        fetch_tag   = '0;
        fetch_rdata = '0;
        data_tag    = '0;
        data_rdata  = '0;
        if (ret_valid) begin
            case (ret_owner)
                mem_arb_pkg::own_data: begin
                    data_tag   = mem_tag;
                    data_rdata = mem_rdata;
                end
                mem_arb_pkg::own_fetch: begin
                    fetch_tag   = mem_tag;
                    fetch_rdata = mem_rdata;
                end
                default: begin
                    // stray tag, nobody sees it
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // memory hands out only free tags, except one freed this very cycle
    issue_tag_free: assert property (
        @(posedge clock) disable iff (reset)
        (issue_owner != mem_arb_pkg::own_none) |->
            ((owner_table[issue_tag] == mem_arb_pkg::own_none) ||
             (ret_valid && mem_tag == issue_tag))
    ) else $error("issued tag %0d already outstanding", issue_tag);

    // every return matches a load accepted earlier
    return_tag_outstanding: assert property (
        @(posedge clock) disable iff (reset)
        ret_valid |-> (owner_table[mem_tag] != mem_arb_pkg::own_none)
    ) else $error("returned tag %0d not outstanding", mem_tag);

    // selector reports an owner only with a real acceptance tag
    issue_tag_nonzero: assert property (
        @(posedge clock) disable iff (reset)
        (issue_owner != mem_arb_pkg::own_none) |-> (issue_tag != '0)
    ) else $error("load recorded with tag zero");

endmodule

/* verilog/mem_port_arbiter.sv */
// memory port arbiter top
// shares one memory port between instruction fetch and load/store
// many loads may be outstanding, returns are routed by tag

`timescale 1ns/1ps

module mem_port_arbiter #(
    parameter int addr_width = mem_arb_pkg::xlen
) (
    input  logic                      clock,
    input  logic                      reset,

    // fetch side
    input  logic                      fetch_request,
    input  logic [addr_width-1:0]     fetch_addr,
    output mem_arb_pkg::mem_tag_t     fetch_response,
    output mem_arb_pkg::mem_tag_t     fetch_tag,
    output mem_arb_pkg::mem_data_t    fetch_rdata,
    output logic                      fetch_stall,

    // data side
    input  mem_arb_pkg::bus_command_t data_command,
    input  logic [addr_width-1:0]     data_addr,
    input  mem_arb_pkg::mem_data_t    data_wdata,
    input  mem_arb_pkg::mem_size_t    data_size,
    output mem_arb_pkg::mem_tag_t     data_response,
    output mem_arb_pkg::mem_tag_t     data_tag,
    output mem_arb_pkg::mem_data_t    data_rdata,
    output logic                      data_stall,

    // memory port
    output mem_arb_pkg::bus_command_t mem_command,
    output logic [addr_width-1:0]     mem_addr,
    output mem_arb_pkg::mem_data_t    mem_wdata,
    output mem_arb_pkg::mem_size_t    mem_size,
    input  mem_arb_pkg::mem_tag_t     mem_response,
    input  mem_arb_pkg::mem_tag_t     mem_tag,
    input  mem_arb_pkg::mem_data_t    mem_rdata
);

    // accepted load, selector to table
    mem_arb_pkg::requester_t issue_owner;
    mem_arb_pkg::mem_tag_t   issue_tag;

    ////////////////////////////////////////////////////////////
    // command side
    ////////////////////////////////////////////////////////////

    request_select #(
        .addr_width (addr_width)
    ) i_request_select (
        .fetch_request  (fetch_request),
        .fetch_addr     (fetch_addr),
        .data_command   (data_command),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_size      (data_size),
        .mem_response   (mem_response),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_size       (mem_size),
        .fetch_response (fetch_response),
        .data_response  (data_response),
        .fetch_stall    (fetch_stall),
        .data_stall     (data_stall),
        .issue_owner    (issue_owner),
        .issue_tag      (issue_tag)
    );

    ////////////////////////////////////////////////////////////
    // return side
    ////////////////////////////////////////////////////////////

    tag_owner_table i_tag_owner_table (
        .clock       (clock),
        .reset       (reset),
        .issue_owner (issue_owner),
        .issue_tag   (issue_tag),
        .mem_tag     (mem_tag),
        .mem_rdata   (mem_rdata),
        .fetch_tag   (fetch_tag),
        .fetch_rdata (fetch_rdata),
        .data_tag    (data_tag),
        .data_rdata  (data_rdata)
    );

endmodule

/* dv/tb_mem_port_arbiter.sv */
// testbench for the memory port arbiter
// random fetch and load/store traffic against a behavioral memory
// a reference model tracks tag owners and the expected load data

`timescale 1ns/1ps

module tb_mem_port_arbiter;

    localparam int reset_cycles   = 4;
    localparam int idle_cycles    = 2;
    localparam int phase_cycles   = 500;
    localparam int num_phases     = 3;
    localparam int drain_margin   = 150;
    localparam int timeout_cycles = reset_cycles + idle_cycles
                                    + num_phases * (phase_cycles + drain_margin);

    logic                      clock;
    logic                      reset;
    logic                      fetch_request;
    logic [31:0]               fetch_addr;
    mem_arb_pkg::mem_tag_t     fetch_response;
    mem_arb_pkg::mem_tag_t     fetch_tag;
    mem_arb_pkg::mem_data_t    fetch_rdata;
    logic                      fetch_stall;
    mem_arb_pkg::bus_command_t data_command;
    logic [31:0]               data_addr;
    mem_arb_pkg::mem_data_t    data_wdata;
    mem_arb_pkg::mem_size_t    data_size;
    mem_arb_pkg::mem_tag_t     data_response;
    mem_arb_pkg::mem_tag_t     data_tag;
    mem_arb_pkg::mem_data_t    data_rdata;
    logic                      data_stall;
    mem_arb_pkg::bus_command_t mem_command;
    logic [31:0]               mem_addr;
    mem_arb_pkg::mem_data_t    mem_wdata;
    mem_arb_pkg::mem_size_t    mem_size;
    mem_arb_pkg::mem_tag_t     mem_response;
    mem_arb_pkg::mem_tag_t     mem_tag;
    mem_arb_pkg::mem_data_t    mem_rdata;

    // reference model, per tag
    mem_arb_pkg::requester_t exp_owner [mem_arb_pkg::num_tags];
    mem_arb_pkg::mem_data_t  exp_data  [mem_arb_pkg::num_tags];

    // behavioral memory state, per tag
    logic        mem_busy      [mem_arb_pkg::num_tags];
    int          mem_due       [mem_arb_pkg::num_tags];
    logic [31:0] mem_load_addr [mem_arb_pkg::num_tags];

    integer seed = 32'h175efe14;
    int     cycle = 0;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     loads_accepted;
    int     loads_returned;
    int     stores_accepted;
    int     errors_before;

    // requester saw its acceptance, retire at next drive
    logic data_taken;
    logic fetch_taken;

    mem_port_arbiter #(
        .addr_width (mem_arb_pkg::xlen)
    ) i_dut (
        .clock          (clock),
        .reset          (reset),
        .fetch_request  (fetch_request),
        .fetch_addr     (fetch_addr),
        .fetch_response (fetch_response),
        .fetch_tag      (fetch_tag),
        .fetch_rdata    (fetch_rdata),
        .fetch_stall    (fetch_stall),
        .data_command   (data_command),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_size      (data_size),
        .data_response  (data_response),
        .data_tag       (data_tag),
        .data_rdata     (data_rdata),
        .data_stall     (data_stall),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_size       (mem_size),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_rdata      (mem_rdata)
    );

    initial begin
        clock = 1'b0;
    end

    always #4 clock = ~clock;

    // cycle count and run limit
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // random helpers and memory pattern
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // true with probability rate/16
    function automatic logic chance(input logic [3:0] rate);
        logic [31:0] r;
        r = rand_word();
        return r[3:0] < rate;
    endfunction

    // load data, every address bit shows up in the word
    function automatic mem_arb_pkg::mem_data_t load_pattern(input logic [31:0] addr);
        return {addr ^ 32'hc3a5_5a3c, ~addr};
    endfunction

    // a due tag, scan starts at a random slot so order varies
    function automatic int pick_return();
        int start;
        int t;
        logic [31:0] r;
        r = rand_word();
        start = {28'd0, r[3:0]};
        for (int i = 0; i < mem_arb_pkg::num_tags; i++) begin
            t = (start + i) % mem_arb_pkg::num_tags;
            if (t != 0 && mem_busy[t] && mem_due[t] <= cycle) begin
                return t;
            end
        end
        return 0;
    endfunction

    // free tag, the one returning this cycle counts as free
    function automatic int pick_free_tag(input int ret);
        int start;
        int t;
        logic [31:0] r;
        r = rand_word();
        start = {28'd0, r[3:0]};
        for (int i = 0; i < mem_arb_pkg::num_tags; i++) begin
            t = (start + i) % mem_arb_pkg::num_tags;
            if (t != 0 && (!mem_busy[t] || t == ret)) begin
                return t;
            end
        end
        return 0;
    endfunction

    function automatic int count_outstanding();
        int n;
        n = 0;
        for (int i = 1; i < mem_arb_pkg::num_tags; i++) begin
            if (mem_busy[i] || exp_owner[i] != mem_arb_pkg::own_none) begin
                n++;
            end
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("FAILED %s: expected 0x%0h, got 0x%0h at cycle %0d",
                     name, expected, got, cycle);
        end
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR %s at cycle %0d", what, cycle);
    endtask

    task automatic check_outputs();
        logic                    data_present;
        logic                    fetch_on_bus;
        mem_arb_pkg::requester_t owner;
        data_present = (data_command != mem_arb_pkg::bus_none);
        fetch_on_bus = fetch_request && !data_present;
        // command path, data first
        if (data_present) begin
            check_value("mem_command", 64'(mem_command), 64'(data_command));
            check_value("mem_addr", 64'(mem_addr), 64'(data_addr));
            check_value("mem_wdata", mem_wdata, data_wdata);
            check_value("mem_size", 64'(mem_size), 64'(data_size));
        end else if (fetch_request) begin
            check_value("mem_command", 64'(mem_command), 64'(mem_arb_pkg::bus_load));
            check_value("mem_addr", 64'(mem_addr), 64'(fetch_addr));
            check_value("mem_size", 64'(mem_size), 64'(mem_arb_pkg::size_double));
        end else begin
            check_value("mem_command", 64'(mem_command), 64'(mem_arb_pkg::bus_none));
        end
        // acceptance goes only to the side on the bus
        check_value("data_response", 64'(data_response),
                    data_present ? 64'(mem_response) : 64'd0);
        check_value("fetch_response", 64'(fetch_response),
                    fetch_on_bus ? 64'(mem_response) : 64'd0);
        check_value("data_stall", 64'(data_stall), 64'(data_present && mem_response == '0));
        // blocked by data or refused by memory
        check_value("fetch_stall", 64'(fetch_stall),
                    64'(fetch_request && (data_present || mem_response == '0)));
        // return routing by model owner
        owner = mem_arb_pkg::own_none;
        if (mem_tag != '0) begin
            owner = exp_owner[mem_tag];
        end
        check_value("data_tag", 64'(data_tag),
                    (owner == mem_arb_pkg::own_data) ? 64'(mem_tag) : 64'd0);
        check_value("data_rdata", data_rdata,
                    (owner == mem_arb_pkg::own_data) ? exp_data[mem_tag] : 64'd0);
        check_value("fetch_tag", 64'(fetch_tag),
                    (owner == mem_arb_pkg::own_fetch) ? 64'(mem_tag) : 64'd0);
        check_value("fetch_rdata", fetch_rdata,
                    (owner == mem_arb_pkg::own_fetch) ? exp_data[mem_tag] : 64'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // model and memory update
    ////////////////////////////////////////////////////////////

    task automatic update_state();
        int          t;
        logic [31:0] r;
        logic        data_present;
        logic        is_load;
        data_present = (data_command != mem_arb_pkg::bus_none);
        // returns as seen on the requester outputs
        if (data_tag != '0) begin
            loads_returned++;
        end
        if (fetch_tag != '0) begin
            loads_returned++;
        end
        // free first, a same-cycle re-issue overwrites
        if (mem_tag != '0) begin
            t = {28'd0, mem_tag};
            exp_owner[t] = mem_arb_pkg::own_none;
            mem_busy[t]  = 1'b0;
        end
        if (mem_response != '0) begin
            t = {28'd0, mem_response};
            is_load = data_present ? (data_command == mem_arb_pkg::bus_load) : 1'b1;
            if (is_load) begin
                r = rand_word();
                exp_owner[t] = data_present ? mem_arb_pkg::own_data : mem_arb_pkg::own_fetch;
                exp_data[t]  = load_pattern(data_present ? data_addr : fetch_addr);
                // memory side keeps what it saw on the port
                mem_busy[t]      = 1'b1;
                mem_due[t]       = cycle + 1 + {29'd0, r[2:0]};
                mem_load_addr[t] = mem_addr;
                loads_accepted++;
            end else begin
                stores_accepted++;
            end
            data_taken  = data_present;
            fetch_taken = !data_present;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one clock of stimulus
    ////////////////////////////////////////////////////////////

    task automatic step_cycle(input logic [3:0] data_rate, input logic [3:0] store_rate,
                              input logic [3:0] fetch_rate, input logic [3:0] accept_rate,
                              input logic allow_new);
        int          ret;
        int          tag;
        logic [31:0] r;
        @(posedge clock);
        #1;
        if (data_taken) begin
            data_command = mem_arb_pkg::bus_none;
        end
        if (fetch_taken) begin
            fetch_request = 1'b0;
        end
        data_taken  = 1'b0;
        fetch_taken = 1'b0;
        // new requests only from an idle side
        if (allow_new && data_command == mem_arb_pkg::bus_none && chance(data_rate)) begin
            data_command = chance(store_rate) ? mem_arb_pkg::bus_store : mem_arb_pkg::bus_load;
            data_addr    = rand_word();
            data_wdata   = {rand_word(), rand_word()};
            r            = rand_word();
            data_size    = mem_arb_pkg::mem_size_t'(r[1:0]);
        end
        if (allow_new && !fetch_request && chance(fetch_rate)) begin
            r             = rand_word();
            fetch_request = 1'b1;
            fetch_addr    = {r[31:3], 3'b000};
        end
        // at most one return per cycle
        ret          = pick_return();
        mem_tag      = mem_arb_pkg::mem_tag_t'(ret);
        mem_rdata    = (ret != 0) ? load_pattern(mem_load_addr[ret]) : '0;
        mem_response = '0;
        #1;
        // memory answers the command it sees this cycle
        if (mem_command != mem_arb_pkg::bus_none && chance(accept_rate)) begin
            tag          = pick_free_tag(ret);
            mem_response = mem_arb_pkg::mem_tag_t'(tag);
        end
        #1;
        check_outputs();
        update_state();
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    // random traffic, then drain until nothing is held or outstanding
    task automatic run_phase(input string name, input logic [3:0] data_rate,
                             input logic [3:0] store_rate, input logic [3:0] fetch_rate,
                             input logic [3:0] accept_rate);
        int errors_at_start;
        errors_at_start = error_count;
        loads_accepted  = 0;
        loads_returned  = 0;
        stores_accepted = 0;
        repeat (phase_cycles) begin
            step_cycle(data_rate, store_rate, fetch_rate, accept_rate, 1'b1);
        end
        while (data_command != mem_arb_pkg::bus_none || fetch_request ||
               count_outstanding() != 0) begin
            step_cycle(data_rate, store_rate, fetch_rate, accept_rate, 1'b0);
        end
        if (loads_returned != loads_accepted) begin
            report_problem("accepted loads and routed returns do not match after drain");
        end
        $display("  %s: loads %0d, returned %0d, stores %0d",
                 name, loads_accepted, loads_returned, stores_accepted);
        finish_test(name, errors_at_start);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset           = 1'b1;
        fetch_request   = 1'b0;
        fetch_addr      = '0;
        data_command    = mem_arb_pkg::bus_none;
        data_addr       = '0;
        data_wdata      = '0;
        data_size       = mem_arb_pkg::size_byte;
        mem_response    = '0;
        mem_tag         = '0;
        mem_rdata       = '0;
        data_taken      = 1'b0;
        fetch_taken     = 1'b0;
        error_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        loads_accepted  = 0;
        loads_returned  = 0;
        stores_accepted = 0;
        for (int i = 0; i < mem_arb_pkg::num_tags; i++) begin
            exp_owner[i]     = mem_arb_pkg::own_none;
            exp_data[i]      = '0;
            mem_busy[i]      = 1'b0;
            mem_due[i]       = 0;
            mem_load_addr[i] = '0;
        end
        repeat (reset_cycles) begin
            @(posedge clock);
        end
        #1;
        reset = 1'b0;

        // idle port right after reset
        errors_before = error_count;
        repeat (idle_cycles) begin
            step_cycle(4'd0, 4'd0, 4'd0, 4'd0, 1'b0);
        end
        finish_test("reset_idle", errors_before);

        run_phase("fetch_only", 4'd0, 4'd0, 4'd12, 4'd10);
        run_phase("mixed_traffic", 4'd8, 4'd6, 4'd12, 4'd9);
        run_phase("store_heavy", 4'd12, 4'd13, 4'd6, 4'd11);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/mem_arb_pkg.sv
verilog/request_select.sv
verilog/tag_owner_table.sv
verilog/mem_port_arbiter.sv
dv/tb_mem_port_arbiter.sv

/* Makefile */
# Verilator build for the memory port arbiter

VERILATOR  ?= verilator
FILELIST   := verilog.f
TOP        := tb_mem_port_arbiter
RTL_TOP    := mem_port_arbiter
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := Simulation completed successfully

SOURCES    := $(wildcard verilog/*.sv dv/*.sv)
SIM_EXE    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the run prints the pass message
sim: $(SIM_EXE)
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
